/* cpu_pkg.sv */
// ----------------------------
// Shared ISA definitions for the five-stage core
// Word addressed; opcode always in bits 31..27
// ----------------------------
package cpu_pkg;

    // Kept opcodes only
    typedef enum logic [4:0] {
        OP_ALU  = 5'b00000,
        OP_J    = 5'b00001,
        OP_BNE  = 5'b00010,
        OP_JAL  = 5'b00011,
        OP_JR   = 5'b00100,
        OP_ADDI = 5'b00101,
        OP_BLT  = 5'b00110,
        OP_SW   = 5'b00111,
        OP_LW   = 5'b01000
    } opcode_t;

    typedef enum logic [4:0] {
        ALU_ADD = 5'b00000,
        ALU_SUB = 5'b00001,
        ALU_AND = 5'b00010,
        ALU_OR  = 5'b00011,
        ALU_SLL = 5'b00100,
        ALU_SRA = 5'b00101
    } alu_op_t;

    // ----------------------------
    // Instruction word, three views
    // ----------------------------
    typedef union packed {
        struct packed {
            opcode_t     opcode;
            logic [4:0]  rd;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [4:0]  shamt;
            alu_op_t     alu_op;
            logic [1:0]  pad;    // Unused
        } r;
        struct packed {
            opcode_t            opcode;
            logic [4:0]         rd;
            logic [4:0]         rs;
            logic signed [16:0] imm;
        } i;
        struct packed {
            opcode_t     opcode;
            logic [26:0] target;
        } j;
    } instr_u;

    typedef enum logic [1:0] {
        BYP_REG    = 2'b00,    // Register file value
        BYP_FROM_W = 2'b01,
        BYP_FROM_M = 2'b10
    } byp_sel_t;

    localparam logic [31:0] NOP      = 32'h0000_0000;    // add $0,$0,$0
    localparam logic [4:0]  LINK_REG = 5'd31;

    // Port A source; branches and jr read rd here
    function automatic logic [4:0] src_a(input instr_u ins);
        case (ins.r.opcode)
            OP_ALU, OP_ADDI, OP_LW, OP_SW: return ins.r.rs;
            OP_BNE, OP_BLT, OP_JR:         return ins.r.rd;
            default:                       return 5'd0;
        endcase
    endfunction

    // Port B source; store data is rd
    function automatic logic [4:0] src_b(input instr_u ins);
        case (ins.r.opcode)
            OP_ALU:         return ins.r.rt;
            OP_SW:          return ins.r.rd;
            OP_BNE, OP_BLT: return ins.r.rs;
            default:        return 5'd0;
        endcase
    endfunction

    function automatic logic [4:0] dest(input instr_u ins);
        return (ins.r.opcode == OP_JAL) ? LINK_REG : ins.r.rd;
    endfunction

    // Register write, never to $0
    function automatic logic writes_rd(input instr_u ins);
        case (ins.r.opcode)
            OP_ALU, OP_ADDI, OP_LW, OP_JAL: return dest(ins) != 5'd0;
            default:                        return 1'b0;
        endcase
    endfunction

endpackage

/* hazard_if.sv */
// ----------------------------
// Register numbers and bypass/stall decisions
// Dest numbers of $0 always come with writes low
// ----------------------------
`timescale 1ns/100ps

interface hazard_if;
    logic [4:0]        d_rs, d_rt;            // Sources in D
    logic              stall;
    logic [4:0]        x_rs, x_rt, x_dest;
    logic              x_is_load, x_writes;
    cpu_pkg::byp_sel_t sel_a, sel_b;          // X operand muxes
    logic [4:0]        m_dest;                // Store data reg when M holds sw
    logic              m_writes, m_is_store_rt;
    logic [4:0]        w_dest;
    logic              w_writes;
    logic              sel_store;             // W value into store data

    modport decode  (output d_rs, d_rt, input stall);
    modport execute (output x_rs, x_rt, x_dest, x_is_load, x_writes, input sel_a, sel_b);
    modport mem_wb  (output m_dest, m_writes, m_is_store_rt, w_dest, w_writes,
                     input sel_store);
    modport hazard  (input d_rs, d_rt, x_rs, x_rt, x_dest, x_is_load, x_writes,
                     m_dest, m_writes, m_is_store_rt, w_dest, w_writes,
                     output stall, sel_a, sel_b, sel_store);
endinterface

/* fetch_stage.sv */
// ----------------------------
// PC and FD register
// Imem read is combinational, one word per cycle
// ----------------------------
`timescale 1ns/100ps

module fetch_stage #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic            clock,
    input  logic            arst_n,
    input  cpu_pkg::instr_u q_imem,
    input  logic            redirect,        // Taken branch or jump in X
    input  logic [31:0]     target,
    input  logic            stall,           // Load-use hold
    output logic [31:0]     address_imem,
    output logic [31:0]     d_pc,            // PC+1 of the D instruction
    output cpu_pkg::instr_u d_instr
);
    logic [31:0] pc;
    logic [31:0] pc_plus1;

    assign address_imem = pc;
    assign pc_plus1     = pc + 32'd1;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc      <= RESET_PC;
            d_instr <= cpu_pkg::NOP;
        end else if (redirect) begin
            pc      <= target;
            d_instr <= cpu_pkg::NOP;    // Squash wrong-path fetch
        end else if (!stall) begin
            pc      <= pc_plus1;
            d_instr <= q_imem;
        end
    end

    // Link and branch base
    always_ff @(posedge clock) begin
        if (!stall) d_pc <= pc_plus1;
    end

endmodule

/* decode_stage.sv */
// ----------------------------
// Register read and DX register
// Relies on a write-through register file, no W-to-D bypass
// ----------------------------
`timescale 1ns/100ps

module decode_stage (
    input  logic            clock,
    input  logic            arst_n,
    input  logic [31:0]     d_pc,
    input  cpu_pkg::instr_u d_instr,
    input  logic [31:0]     data_read_reg_a,
    input  logic [31:0]     data_read_reg_b,
    input  logic            flush,
    output logic [4:0]      ctrl_read_reg_a,
    output logic [4:0]      ctrl_read_reg_b,
    output logic [31:0]     x_pc,
    output cpu_pkg::instr_u x_instr,
    output logic [31:0]     x_val_a,
    output logic [31:0]     x_val_b,
    hazard_if.decode        hz
);
    logic bubble;
    logic is_jal;

    // Read ports follow the instruction view
    assign ctrl_read_reg_a = cpu_pkg::src_a(d_instr);
    assign ctrl_read_reg_b = cpu_pkg::src_b(d_instr);

    assign hz.d_rs = ctrl_read_reg_a;    // Zero when not a real source
    assign hz.d_rt = ctrl_read_reg_b;

    assign bubble = hz.stall || flush;
    assign is_jal = (d_instr.r.opcode == cpu_pkg::OP_JAL);

    //----------------------------
    // DX register
    //----------------------------
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            x_instr <= cpu_pkg::NOP;
        end else begin
            x_instr <= bubble ? cpu_pkg::NOP : d_instr;
        end
    end

    // jal becomes an add of PC+1 into $31
    // Port B reads $0, so the ALU sees PC+1 plus zero
    always_ff @(posedge clock) begin
        x_pc    <= d_pc;
        x_val_a <= is_jal ? d_pc : data_read_reg_a;
        x_val_b <= data_read_reg_b;
    end

endmodule

/* hazard_unit.sv */
// ----------------------------
// Load-use stall and bypass selects
// Newest producer wins, M over W
// ----------------------------
`timescale 1ns/100ps

module hazard_unit (
    hazard_if.hazard hz
);
    logic use_rs;
    logic use_rt;

    // Operand source for one X register number
    function automatic cpu_pkg::byp_sel_t pick(
        input logic [4:0] r,
        input logic [4:0] m_dest,
        input logic       m_writes,
        input logic [4:0] w_dest,
        input logic       w_writes
    );
        if (m_writes && m_dest == r) begin
            return cpu_pkg::BYP_FROM_M;
        end else if (w_writes && w_dest == r) begin
            return cpu_pkg::BYP_FROM_W;
        end
        return cpu_pkg::BYP_REG;
    endfunction

    //----------------------------
    // Load-use
    //----------------------------
    assign use_rs = (hz.d_rs != 5'd0) && (hz.d_rs == hz.x_dest);
    assign use_rt = (hz.d_rt != 5'd0) && (hz.d_rt == hz.x_dest);

    assign hz.stall = hz.x_is_load && hz.x_writes && (use_rs || use_rt);    // One cycle

    //----------------------------
    // Bypass
    //----------------------------
    // Writes flag low for $0, so reads of $0 stay on the register path
    assign hz.sel_a = pick(hz.x_rs, hz.m_dest, hz.m_writes, hz.w_dest, hz.w_writes);
    assign hz.sel_b = pick(hz.x_rt, hz.m_dest, hz.m_writes, hz.w_dest, hz.w_writes);

    // Store in M whose data reg W is writing
    assign hz.sel_store = hz.m_is_store_rt && hz.w_writes && (hz.w_dest == hz.m_dest);

endmodule

/* alu.sv */
// ----------------------------
// Combinational ALU, no overflow flag
// Flags compare a with b as signed
// ----------------------------
`timescale 1ns/100ps

module alu (
    input  logic [31:0]      a,
    input  logic [31:0]      b,
    input  cpu_pkg::alu_op_t op,
    input  logic [4:0]       shamt,
    output logic [31:0]      result,
    output logic             neq,
    output logic             lt
);
    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD: result = a + b;
            cpu_pkg::ALU_SUB: result = a - b;
            cpu_pkg::ALU_AND: result = a & b;
            cpu_pkg::ALU_OR:  result = a | b;
            cpu_pkg::ALU_SLL: result = a << shamt;
            cpu_pkg::ALU_SRA: result = $signed(a) >>> shamt;    // Keeps sign
            default:          result = 32'd0;                   // Unused codes
        endcase
    end

    // Branch conditions
    assign neq = (a != b);
    assign lt  = ($signed(a) < $signed(b));

endmodule

/* execute_stage.sv */
// ----------------------------
// Bypass, ALU, branch resolution, XM register
// Branch decision is combinational from DX
// ----------------------------
`timescale 1ns/100ps

module execute_stage (
    input  logic            clock,
    input  logic            arst_n,
    input  logic [31:0]     x_pc,            // PC+1 of this instruction
    input  cpu_pkg::instr_u x_instr,
    input  logic [31:0]     x_val_a,
    input  logic [31:0]     x_val_b,
    input  logic [31:0]     m_value,         // ALU result or load data in M
    input  logic [31:0]     w_value,
    output logic            redirect,
    output logic [31:0]     target,
    output cpu_pkg::instr_u m_instr,
    output logic [31:0]     m_alu,
    output logic [31:0]     m_store_data,
    hazard_if.execute       hz
);
    logic [31:0]      op_a, op_b;
    logic [31:0]      imm;
    logic             use_imm;
    logic [31:0]      alu_b;
    cpu_pkg::alu_op_t alu_op;
    logic [31:0]      alu_result;
    logic             neq, lt;

    assign hz.x_rs      = cpu_pkg::src_a(x_instr);
    assign hz.x_rt      = cpu_pkg::src_b(x_instr);
    assign hz.x_dest    = cpu_pkg::dest(x_instr);
    assign hz.x_is_load = (x_instr.r.opcode == cpu_pkg::OP_LW);
    assign hz.x_writes  = cpu_pkg::writes_rd(x_instr);

    //----------------------------
    // Operands
    //----------------------------
    always_comb begin
        case (hz.sel_a)
            cpu_pkg::BYP_FROM_M: op_a = m_value;
            cpu_pkg::BYP_FROM_W: op_a = w_value;
            default:             op_a = x_val_a;
        endcase
        case (hz.sel_b)
            cpu_pkg::BYP_FROM_M: op_b = m_value;
            cpu_pkg::BYP_FROM_W: op_b = w_value;
            default:             op_b = x_val_b;
        endcase
    end

    assign imm     = {{15{x_instr.i.imm[16]}}, x_instr.i.imm};    // Sign extend
    assign use_imm = (x_instr.i.opcode == cpu_pkg::OP_ADDI) ||
                     (x_instr.i.opcode == cpu_pkg::OP_LW)   ||
                     (x_instr.i.opcode == cpu_pkg::OP_SW);
    assign alu_b   = use_imm ? imm : op_b;

    // Non-R types add; jal adds PC+1 and zero
    assign alu_op = (x_instr.r.opcode == cpu_pkg::OP_ALU) ? x_instr.r.alu_op
                                                          : cpu_pkg::ALU_ADD;

    alu u_alu (
        .a      (op_a),
        .b      (alu_b),
        .op     (alu_op),
        .shamt  (x_instr.r.shamt),
        .result (alu_result),
        .neq    (neq),
        .lt     (lt)
    );

    //----------------------------
    // Branch and jump
    //----------------------------
    always_comb begin
        redirect = 1'b0;
        target   = x_pc + imm;    // Branch target
        case (x_instr.r.opcode)
            cpu_pkg::OP_J, cpu_pkg::OP_JAL: begin
                redirect = 1'b1;
                target   = {5'd0, x_instr.j.target};
            end
            cpu_pkg::OP_JR: begin
                redirect = 1'b1;
                target   = op_a;    // Bypassed rd
            end
            cpu_pkg::OP_BNE: redirect = neq;
            cpu_pkg::OP_BLT: redirect = lt;    // rd < rs
            default:         redirect = 1'b0;
        endcase
    end

    // jal is kept, it writes $31 later
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            m_instr <= cpu_pkg::NOP;
        end else begin
            m_instr <= x_instr;
        end
    end

    always_ff @(posedge clock) begin
        m_alu        <= alu_result;
        m_store_data <= op_b;    // Already bypassed from M/W
    end

endmodule

/* mem_wb_stage.sv */
// ----------------------------
// Data memory access, MW register, writeback
// Dmem write happens at the edge while wren is high
// ----------------------------
`timescale 1ns/100ps

module mem_wb_stage (
    input  logic            clock,
    input  logic            arst_n,
    input  cpu_pkg::instr_u m_instr,
    input  logic [31:0]     m_alu,
    input  logic [31:0]     m_store_data,
    input  logic [31:0]     q_dmem,
    output logic [31:0]     address_dmem,
    output logic [31:0]     data,
    output logic            wren,
    output logic [31:0]     m_value,
    output logic [31:0]     w_value,
    output logic            ctrl_write_enable,
    output logic [4:0]      ctrl_write_reg,
    output logic [31:0]     data_write_reg,
    hazard_if.mem_wb        hz
);
    cpu_pkg::instr_u w_instr;
    logic [31:0]     w_alu;
    logic [31:0]     w_mem;
    logic            m_is_load;

    //----------------------------
    // M stage
    //----------------------------
    assign m_is_load    = (m_instr.r.opcode == cpu_pkg::OP_LW);
    assign address_dmem = m_alu;
    assign wren         = (m_instr.r.opcode == cpu_pkg::OP_SW);
    assign data         = hz.sel_store ? w_value : m_store_data;
    assign m_value      = m_is_load ? q_dmem : m_alu;    // Feeds X bypass

    // For sw, m_dest is the store data register
    assign hz.m_dest        = cpu_pkg::dest(m_instr);
    assign hz.m_writes      = cpu_pkg::writes_rd(m_instr);
    assign hz.m_is_store_rt = wren;

    // MW
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            w_instr <= cpu_pkg::NOP;
        end else begin
            w_instr <= m_instr;
        end
    end

    always_ff @(posedge clock) begin
        w_alu <= m_alu;
        w_mem <= q_dmem;
    end

    //----------------------------
    // W stage
    //----------------------------
    assign w_value = (w_instr.r.opcode == cpu_pkg::OP_LW) ? w_mem : w_alu;

    assign ctrl_write_enable = cpu_pkg::writes_rd(w_instr);    // Low for $0
    assign ctrl_write_reg    = cpu_pkg::dest(w_instr);
    assign data_write_reg    = w_value;

    assign hz.w_dest   = ctrl_write_reg;
    assign hz.w_writes = ctrl_write_enable;

endmodule

/* processor.sv */
// ----------------------------
// Five-stage in-order core, 32-bit, word addressed
// Imem, dmem and register file are external, all read combinationally
// Register file must be write-through
// ----------------------------
`timescale 1ns/100ps

module processor #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clock,
    input  logic        arst_n,

    // Imem
    output logic [31:0] address_imem,
    input  logic [31:0] q_imem,

    // Dmem
    output logic [31:0] address_dmem,
    output logic [31:0] data,
    output logic        wren,
    input  logic [31:0] q_dmem,

    // Register file
    output logic        ctrl_write_enable,
    output logic [4:0]  ctrl_write_reg,
    output logic [31:0] data_write_reg,
    output logic [4:0]  ctrl_read_reg_a,
    output logic [4:0]  ctrl_read_reg_b,
    input  logic [31:0] data_read_reg_a,
    input  logic [31:0] data_read_reg_b
);
    // F/D
    logic [31:0]     d_pc;
    cpu_pkg::instr_u d_instr;
    // D/X
    logic [31:0]     x_pc, x_val_a, x_val_b;
    cpu_pkg::instr_u x_instr;
    // X/M and redirect
    logic            redirect;
    logic [31:0]     target;
    cpu_pkg::instr_u m_instr;
    logic [31:0]     m_alu, m_store_data;
    // Bypass values
    logic [31:0]     m_value, w_value;

    hazard_if hz ();

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clock        (clock),
        .arst_n       (arst_n),
        .q_imem       (q_imem),
        .redirect     (redirect),
        .target       (target),
        .stall        (hz.stall),
        .address_imem (address_imem),
        .d_pc         (d_pc),
        .d_instr      (d_instr)
    );

    decode_stage u_decode (
        .clock           (clock),
        .arst_n          (arst_n),
        .d_pc            (d_pc),
        .d_instr         (d_instr),
        .data_read_reg_a (data_read_reg_a),
        .data_read_reg_b (data_read_reg_b),
        .flush           (redirect),    // Second discarded slot
        .ctrl_read_reg_a (ctrl_read_reg_a),
        .ctrl_read_reg_b (ctrl_read_reg_b),
        .x_pc            (x_pc),
        .x_instr         (x_instr),
        .x_val_a         (x_val_a),
        .x_val_b         (x_val_b),
        .hz              (hz.decode)
    );

    hazard_unit u_hazard (
        .hz (hz.hazard)
    );

    execute_stage u_execute (
        .clock        (clock),
        .arst_n       (arst_n),
        .x_pc         (x_pc),
        .x_instr      (x_instr),
        .x_val_a      (x_val_a),
        .x_val_b      (x_val_b),
        .m_value      (m_value),
        .w_value      (w_value),
        .redirect     (redirect),
        .target       (target),
        .m_instr      (m_instr),
        .m_alu        (m_alu),
        .m_store_data (m_store_data),
        .hz           (hz.execute)
    );

    mem_wb_stage u_mem_wb (
        .clock             (clock),
        .arst_n            (arst_n),
        .m_instr           (m_instr),
        .m_alu             (m_alu),
        .m_store_data      (m_store_data),
        .q_dmem            (q_dmem),
        .address_dmem      (address_dmem),
        .data              (data),
        .wren              (wren),
        .m_value           (m_value),
        .w_value           (w_value),
        .ctrl_write_enable (ctrl_write_enable),
        .ctrl_write_reg    (ctrl_write_reg),
        .data_write_reg    (data_write_reg),
        .hz                (hz.mem_wb)
    );

endmodule

/* tb_isa_model.svh */
// ------------------------------
// ISA reference model and random program generator, included in the testbench
// Programs start at word 0 and end in a j to itself
// Data registers $0..$6; $31 only written by jal and read by jr
// ------------------------------
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

localparam int PROG_LEN = 48;
localparam int LAST     = PROG_LEN - 1;    // Final self-loop

// Initial state, copied into the memory models during reset
logic [31:0] imem      [256];
logic [31:0] init_dmem [256];
logic [31:0] init_rf   [32];

// Architectural state of the model
logic [31:0] mdl_rf  [32];
logic [31:0] mdl_mem [256];

// Expected writes in program order
logic [4:0]  exp_reg_num  [$];
logic [31:0] exp_reg_val  [$];
logic [31:0] exp_mem_addr [$];
logic [31:0] exp_mem_val  [$];

// ------------------------------
// Encoders
// ------------------------------
function automatic logic [31:0] enc_i(cpu_pkg::opcode_t op, int rd, int rs, int imm);
    cpu_pkg::instr_u ins;
    ins.i.opcode = op;
    ins.i.rd     = rd[4:0];
    ins.i.rs     = rs[4:0];
    ins.i.imm    = imm[16:0];
    return ins;
endfunction

function automatic logic [31:0] enc_j(cpu_pkg::opcode_t op, int target);
    cpu_pkg::instr_u ins;
    ins.j.opcode = op;
    ins.j.target = 27'(target);
    return ins;
endfunction

// R-type with random function and shift amount
function automatic logic [31:0] enc_r(int rd, int rs, int rt);
    cpu_pkg::instr_u ins;
    ins.r.opcode = cpu_pkg::OP_ALU;
    ins.r.rd     = rd[4:0];
    ins.r.rs     = rs[4:0];
    ins.r.rt     = rt[4:0];
    ins.r.shamt  = 5'($urandom % 32);
    ins.r.alu_op = cpu_pkg::alu_op_t'(5'($urandom % 6));
    ins.r.pad    = 2'b00;
    return ins;
endfunction

// Small set, so dependencies come often
function automatic int pick_reg();
    return int'($urandom % 7);
endfunction

// Non-control instruction
function automatic logic [31:0] rand_simple();
    case ($urandom % 4)
        0:       return enc_r(pick_reg(), pick_reg(), pick_reg());
        1:       return enc_i(cpu_pkg::OP_ADDI, pick_reg(), pick_reg(), int'($urandom % 64) - 32);
        2:       return enc_i(cpu_pkg::OP_LW, pick_reg(), pick_reg(), int'($urandom % 256));
        default: return enc_i(cpu_pkg::OP_SW, pick_reg(), pick_reg(), int'($urandom % 256));
    endcase
endfunction

// ------------------------------
// Program generator
// ------------------------------
task automatic gen_program();
    int p;
    int k;
    int kind;
    for (int a = 0; a < 256; a++) imem[a] = cpu_pkg::NOP;
    p = 0;
    while (p < LAST) begin
        kind = int'($urandom % 10);
        if (kind == 0 && p + 5 <= LAST) begin
            // jal to a short body; jr comes back to the j that skips it
            k = 1 + int'($urandom % 2);
            imem[p]     = enc_j(cpu_pkg::OP_JAL, p + 2);
            imem[p + 1] = enc_j(cpu_pkg::OP_J, p + 3 + k);
            for (int b = 0; b < k; b++) imem[p + 2 + b] = rand_simple();
            imem[p + 2 + k] = enc_i(cpu_pkg::OP_JR, 31, 0, 0);
            p = p + 3 + k;
        end else if (kind <= 3) begin
            // Forward branch or j over k filler words
            k = int'($urandom % 4);
            if (p + 1 + k > LAST) k = LAST - p - 1;
            case (kind)
                1:       imem[p] = enc_i(cpu_pkg::OP_BNE, pick_reg(), pick_reg(), k);
                2:       imem[p] = enc_i(cpu_pkg::OP_BLT, pick_reg(), pick_reg(), k);
                default: imem[p] = enc_j(cpu_pkg::OP_J, p + 1 + k);
            endcase
            for (int b = 1; b <= k; b++) imem[p + b] = rand_simple();
            p = p + 1 + k;
        end else begin
            imem[p] = rand_simple();
            p = p + 1;
        end
    end
    imem[LAST] = enc_j(cpu_pkg::OP_J, LAST);
endtask

// ------------------------------
// Reference model
// ------------------------------
function automatic void put_reg(logic [4:0] rd, logic [31:0] v);
    if (rd != 5'd0) begin    // $0 stays zero, no write
        mdl_rf[rd] = v;
        exp_reg_num.push_back(rd);
        exp_reg_val.push_back(v);
    end
endfunction

task automatic run_model();
    cpu_pkg::instr_u ins;
    logic [31:0]     pc, nxt, a, b, d, imm, addr, res;
    int              steps;
    exp_reg_num.delete();
    exp_reg_val.delete();
    exp_mem_addr.delete();
    exp_mem_val.delete();
    for (int i = 0; i < 32; i++) mdl_rf[i] = init_rf[i];
    for (int i = 0; i < 256; i++) mdl_mem[i] = init_dmem[i];
    pc    = 32'd0;
    steps = 0;
    while (pc != LAST && steps < 1000) begin
        ins  = imem[pc[7:0]];
        a    = mdl_rf[ins.r.rs];
        b    = mdl_rf[ins.r.rt];
        d    = mdl_rf[ins.r.rd];    // Store data, branch and jr operand
        imm  = {{15{ins.i.imm[16]}}, ins.i.imm};
        addr = a + imm;
        nxt  = pc + 32'd1;
        case (ins.r.opcode)
            cpu_pkg::OP_ALU: begin
                case (ins.r.alu_op)
                    cpu_pkg::ALU_ADD: res = a + b;
                    cpu_pkg::ALU_SUB: res = a - b;
                    cpu_pkg::ALU_AND: res = a & b;
                    cpu_pkg::ALU_OR:  res = a | b;
                    cpu_pkg::ALU_SLL: res = a << ins.r.shamt;
                    default:          res = $signed(a) >>> ins.r.shamt;
                endcase
                put_reg(ins.r.rd, res);
            end
            cpu_pkg::OP_ADDI: put_reg(ins.i.rd, addr);
            cpu_pkg::OP_LW:   put_reg(ins.i.rd, mdl_mem[addr[7:0]]);    // 256-word wrap
            cpu_pkg::OP_SW: begin
                mdl_mem[addr[7:0]] = d;
                exp_mem_addr.push_back(addr);
                exp_mem_val.push_back(d);
            end
            cpu_pkg::OP_JAL: begin
                put_reg(5'd31, nxt);
                nxt = {5'd0, ins.j.target};
            end
            cpu_pkg::OP_J:   nxt = {5'd0, ins.j.target};
            cpu_pkg::OP_JR:  nxt = d;
            cpu_pkg::OP_BNE: if (d != a) nxt = nxt + imm;
            cpu_pkg::OP_BLT: if ($signed(d) < $signed(a)) nxt = nxt + imm;
            default: ;
        endcase
        pc = nxt;
        steps++;
    end
endtask

// New program, initial state and expected writes
task automatic load_program();
    gen_program();
    init_rf[0] = 32'd0;
    for (int i = 1; i < 32; i++) init_rf[i] = $urandom % 16;    // Equal operands now and then
    for (int i = 0; i < 256; i++) init_dmem[i] = $urandom;
    run_model();
endtask

`endif

/* tb_processor.sv */
// ------------------------------
// Random-program testbench for the processor
// Imem, dmem (256 words) and the write-through register file live here
// RESET_PC is 0, programs are placed at word 0
// ------------------------------
`timescale 1ns/100ps

module tb_processor;
    localparam logic [31:0] RESET_PC   = 32'h0000_0000;
    localparam int          NUM_PROGS  = 8;
    localparam int          MAX_CYCLES = NUM_PROGS * (48 * 3 + 40);

    logic        clock;
    logic        arst_n;
    logic [31:0] address_imem, q_imem;
    logic [31:0] address_dmem, data, q_dmem;
    logic        wren;
    logic        ctrl_write_enable;
    logic [4:0]  ctrl_write_reg, ctrl_read_reg_a, ctrl_read_reg_b;
    logic [31:0] data_write_reg, data_read_reg_a, data_read_reg_b;

    logic [31:0] dmem [256];
    logic [31:0] rf   [32];

    int reg_idx, mem_idx;    // Next expected entries
    int value_errors, extra_errors, zero_errors, reset_errors;
    int total;
    int cycles = 0;

    `include "tb_isa_model.svh"

    processor #(
        .RESET_PC (RESET_PC)
    ) dut_i (
        .clock             (clock),
        .arst_n            (arst_n),
        .address_imem      (address_imem),
        .q_imem            (q_imem),
        .address_dmem      (address_dmem),
        .data              (data),
        .wren              (wren),
        .q_dmem            (q_dmem),
        .ctrl_write_enable (ctrl_write_enable),
        .ctrl_write_reg    (ctrl_write_reg),
        .data_write_reg    (data_write_reg),
        .ctrl_read_reg_a   (ctrl_read_reg_a),
        .ctrl_read_reg_b   (ctrl_read_reg_b),
        .data_read_reg_a   (data_read_reg_a),
        .data_read_reg_b   (data_read_reg_b)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;    // 4 ns
    end

    // ------------------------------
    // Memory and register file models
    // ------------------------------
    assign q_imem = imem[address_imem[7:0]];
    assign q_dmem = dmem[address_dmem[7:0]];

    // Write-through read
    assign data_read_reg_a = (ctrl_write_enable && ctrl_write_reg == ctrl_read_reg_a &&
                              ctrl_read_reg_a != 5'd0) ? data_write_reg : rf[ctrl_read_reg_a];
    assign data_read_reg_b = (ctrl_write_enable && ctrl_write_reg == ctrl_read_reg_b &&
                              ctrl_read_reg_b != 5'd0) ? data_write_reg : rf[ctrl_read_reg_b];

    always @(posedge clock) begin
        if (!arst_n) begin    // Reload initial state
            for (int i = 0; i < 256; i++) dmem[i] <= init_dmem[i];
            for (int i = 0; i < 32; i++) rf[i] <= init_rf[i];
        end else begin
            if (wren) dmem[address_dmem[7:0]] <= data;
            if (ctrl_write_enable && ctrl_write_reg != 5'd0) rf[ctrl_write_reg] <= data_write_reg;
        end
    end

    // ------------------------------
    // Checkers
    // ------------------------------
    task automatic check_reg_write();
        if (ctrl_write_reg == 5'd0) begin
            $display("FAILED at %0t: register write to $0 with %h", $time, data_write_reg);
            zero_errors++;
        end else if (reg_idx >= exp_reg_num.size()) begin
            $display("Extra register write at %0t: $%0d = %h", $time, ctrl_write_reg,
                     data_write_reg);
            extra_errors++;
        end else begin
            if (ctrl_write_reg != exp_reg_num[reg_idx] || data_write_reg != exp_reg_val[reg_idx])
            begin
                $display("FAILED at %0t: reg write %0d expected $%0d=%h, got $%0d=%h", $time,
                         reg_idx, exp_reg_num[reg_idx], exp_reg_val[reg_idx], ctrl_write_reg,
                         data_write_reg);
                value_errors++;
            end
            reg_idx++;
        end
    endtask

    task automatic check_mem_write();
        if (mem_idx >= exp_mem_addr.size()) begin
            $display("Extra memory write at %0t: [%h] = %h", $time, address_dmem, data);
            extra_errors++;
        end else begin
            if (address_dmem != exp_mem_addr[mem_idx] || data != exp_mem_val[mem_idx]) begin
                $display("FAILED at %0t: mem write %0d expected [%h]=%h, got [%h]=%h", $time,
                         mem_idx, exp_mem_addr[mem_idx], exp_mem_val[mem_idx], address_dmem,
                         data);
                value_errors++;
            end
            mem_idx++;
        end
    endtask

    // Mid-cycle sampling, outputs settled
    always @(negedge clock) begin
        if (!arst_n) begin
            reg_idx = 0;
            mem_idx = 0;
            if (wren || ctrl_write_enable || address_imem != RESET_PC) begin
                $display("FAILED at %0t: in reset wren=%b write_enable=%b pc=%h", $time, wren,
                         ctrl_write_enable, address_imem);
                reset_errors++;
            end
        end else begin
            if (ctrl_write_enable) check_reg_write();
            if (wren) check_mem_write();
        end
    end

    task automatic print_counts();
        $display("Errors: %0d wrong values, %0d extra writes, %0d writes to $0, %0d in reset",
                 value_errors, extra_errors, zero_errors, reset_errors);
    endtask

    // ------------------------------
    // Timeout
    // ------------------------------
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run timed out after %0d cycles with expected writes still missing", cycles);
            print_counts();
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        arst_n = 1'b1;
        void'($urandom(32'hc17d));
        for (int prog = 0; prog < NUM_PROGS; prog++) begin
            @(posedge clock);
            arst_n <= 1'b0;
            load_program();
            repeat (3) @(posedge clock);
            arst_n <= 1'b1;
            // All expected writes seen, then a quiet tail
            while (reg_idx < exp_reg_num.size() || mem_idx < exp_mem_addr.size())
                @(posedge clock);
            repeat (10) @(posedge clock);
        end
        total = value_errors + extra_errors + zero_errors + reset_errors;
        print_counts();
        if (total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+.
cpu_pkg.sv
hazard_if.sv
fetch_stage.sv
decode_stage.sv
hazard_unit.sv
alu.sv
execute_stage.sv
mem_wb_stage.sv
processor.sv
tb_processor.sv

/* run.sh */
#!/bin/sh
# Build and run the processor testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module tb_processor -f sources.f
out=$(./obj_dir/Vtb_processor)
echo "$out"
echo "$out" | grep -q "TEST RESULT: PASS"
